/* hw/alu_core_top.sv */
// Execute cluster top; latency from command to result is 4 cycles or more
// Results leave in command order
module alu_core_top
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rstz,
    // Command port
    input  logic    cmd_vld,
    output logic    cmd_rdy,
    input  aluop_t  cmd_op,
    input  regidx_t cmd_rd,
    input  regidx_t cmd_rs1,
    input  regidx_t cmd_rs2,
    input  word_t   cmd_imm,
    input  logic    cmd_use_imm,
    input  logic    cmd_rd_write,
    // Result port
    output logic    res_vld,
    input  logic    res_rdy,
    output regidx_t res_rd,
    output word_t   res_data,
    output logic    res_illegal
);

    // Register file links
    regidx_t rf_raddr1, rf_raddr2, rf_waddr;
    word_t   rf_rdata1, rf_rdata2, rf_wdata;
    logic    rf_we;

    // Decode to execute
    logic    dec_vld, dec_rdy;
    word_t   op1, op2;
    regidx_t rs1, rs2, rd;
    logic    rs1_read, rs2_read, rd_write, illegal;
    logic    neg, rev, cin, uns, eq, inv;
    alusel_t sel;

    // Execute to writeback
    logic    ex_vld, ex_rdy, ex_rd_write, ex_illegal;
    regidx_t ex_rd;
    word_t   ex_result;

    alu_decode u_decode (
        .clk, .rstz,
        .cmd_vld, .cmd_rdy, .cmd_op, .cmd_rd, .cmd_rs1, .cmd_rs2,
        .cmd_imm, .cmd_use_imm, .cmd_rd_write,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .dec_vld, .dec_rdy, .op1, .op2, .rs1, .rs2, .rd,
        .rs1_read, .rs2_read, .rd_write, .illegal,
        .neg, .rev, .cin, .uns, .eq, .inv, .sel
    );

    alu_regfile u_regfile (
        .clk, .rstz,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu_execute u_execute (
        .clk, .rstz,
        .dec_vld, .dec_rdy, .op1, .op2, .rs1, .rs2, .rd,
        .rs1_read, .rs2_read, .rd_write, .illegal,
        .neg, .rev, .cin, .uns, .eq, .inv, .sel,
        .ex_vld, .ex_rdy, .ex_rd, .ex_rd_write, .ex_illegal, .ex_result
    );

    alu_writeback u_writeback (
        .clk, .rstz,
        .ex_vld, .ex_rdy, .ex_rd, .ex_rd_write, .ex_illegal, .ex_result,
        .rf_we, .rf_waddr, .rf_wdata,
        .res_vld, .res_rdy, .res_rd, .res_data, .res_illegal
    );

endmodule

/* hw/alu_decode.sv */
// One-entry command stage; controls are decoded from the held opcode
// Operands are read live from the register file while the entry waits
module alu_decode
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rstz,
    // Command port
    input  logic    cmd_vld,
    output logic    cmd_rdy,
    input  aluop_t  cmd_op,
    input  regidx_t cmd_rd,
    input  regidx_t cmd_rs1,
    input  regidx_t cmd_rs2,
    input  word_t   cmd_imm,
    input  logic    cmd_use_imm,
    input  logic    cmd_rd_write,
    // Register file read ports
    output regidx_t rf_raddr1,
    output regidx_t rf_raddr2,
    input  word_t   rf_rdata1,
    input  word_t   rf_rdata2,
    // To execute
    output logic    dec_vld,
    input  logic    dec_rdy,
    output word_t   op1,
    output word_t   op2,
    output regidx_t rs1,
    output regidx_t rs2,
    output regidx_t rd,
    output logic    rs1_read,
    output logic    rs2_read,
    output logic    rd_write,
    output logic    illegal,
    output logic    neg,
    output logic    rev,
    output logic    cin,
    output logic    uns,
    output logic    eq,
    output logic    inv,
    output alusel_t sel
);

    logic   vld_q;
    aluop_t op_q;
    word_t  imm_q;
    logic   use_imm_q;
    logic   rd_write_q;

    // Take a new command when empty or when execute drains us
    assign cmd_rdy = !vld_q || dec_rdy;
    assign dec_vld = vld_q;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            vld_q <= 1'b0;
        end else if (cmd_vld && cmd_rdy) begin
            vld_q <= 1'b1;
        end else if (dec_rdy) begin
            vld_q <= 1'b0;
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (cmd_vld && cmd_rdy) begin
            op_q       <= cmd_op;
            rd         <= cmd_rd;
            rs1        <= cmd_rs1;
            rs2        <= cmd_rs2;
            imm_q      <= cmd_imm;
            use_imm_q  <= cmd_use_imm;
            rd_write_q <= cmd_rd_write;
        end
    end

    // ==============================
    // Operands
    // ==============================
    assign rf_raddr1 = rs1;
    assign rf_raddr2 = rs2;
    assign op1       = rf_rdata1;
    assign op2       = use_imm_q ? imm_q : rf_rdata2;
    assign rs1_read  = 1'b1;
    assign rs2_read  = !use_imm_q;

    // ==============================
    // Opcode to ALU controls
    // ==============================
    assign illegal  = (op_q > SRA);
    // Illegal commands never write a register
    assign rd_write = rd_write_q && !illegal;

    always_comb begin
        neg = 1'b0;
        rev = 1'b0;
        cin = 1'b0;
        uns = 1'b0;
        eq  = 1'b0;
        inv = 1'b0;
        sel = SEL_ADDER;
        case (op_q)
            SUB: begin
                neg = 1'b1;
                cin = 1'b1;
            end
            AND: sel = SEL_AND;
            OR:  sel = SEL_OR;
            XOR: sel = SEL_XOR;
            SLT, SLTU, SGE, SGEU: begin
                // Ordered compares subtract through the adder
                neg = 1'b1;
                cin = 1'b1;
                uns = (op_q == SLTU) || (op_q == SGEU);
                inv = (op_q == SGE) || (op_q == SGEU);
                sel = SEL_COMP;
            end
            SEQ, SNE: begin
                eq  = 1'b1;
                inv = (op_q == SNE);
                sel = SEL_COMP;
            end
            SLL: begin
                rev = 1'b1;
                sel = SEL_SHIFT;
            end
            SRL: begin
                uns = 1'b1;
                sel = SEL_SHIFT;
            end
            SRA: sel = SEL_SHIFT;
            default: sel = SEL_ADDER;
        endcase
    end

endmodule

/* hw/alu_defines.svh */
// Width and size macros shared by the package and the RTL
// The execute datapath is built for a 32 bit word and a 5 bit shift amount
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Data path width
`define ALU_XLEN 32

// Register index width and register count
`define ALU_REGW 5
`define ALU_NREGS 32

// Shift amount width, log2 of the data width
`define ALU_SHW 5

`endif

/* hw/alu_execute.sv */
// Two-cycle ALU; one operation every 2 cycles, result valid 2 cycles after accept
// Only the output register can hold an unwritten result, so hazards resolve here
`include "alu_defines.svh"

module alu_execute
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rstz,
    // From decode
    input  logic    dec_vld,
    output logic    dec_rdy,
    input  word_t   op1,
    input  word_t   op2,
    input  regidx_t rs1,
    input  regidx_t rs2,
    input  regidx_t rd,
    input  logic    rs1_read,
    input  logic    rs2_read,
    input  logic    rd_write,
    input  logic    illegal,
    input  logic    neg,
    input  logic    rev,
    input  logic    cin,
    input  logic    uns,
    input  logic    eq,
    input  logic    inv,
    input  alusel_t sel,
    // To writeback
    output logic    ex_vld,
    input  logic    ex_rdy,
    output regidx_t ex_rd,
    output logic    ex_rd_write,
    output logic    ex_illegal,
    output word_t   ex_result
);

    ex_state_t state, next_state;
    logic      accept;
    logic      is_pending, stall;
    regidx_t   rpend;
    logic      rs1_hazard, rs2_hazard;
    word_t     a_op, b_op;

    word_t       adder_b;
    logic [15:0] adder_rl, adder_rh0, adder_rh1, adder_rh;
    logic        cout_rl, cout_rh0, cout_rh1, cout;
    word_t       r_adder;

    word_t r_logic;

    logic a_sign, b_sign;
    logic check_uns, check_eq, invert;
    logic eq_lo, eq_hi;
    logic lt, ltu, op_eq, r_comp;

    word_t                 data, p0, p1;
    logic                  shift_in;
    word_t                 tdata;
    logic                  tshift_in, shift_rev;
    logic [`ALU_SHW-1:2]   shamt_hi;
    word_t                 p2, p3, p4, r_shift;

    alusel_t result_sel;
    word_t   r_sel;

    // ==============================
    // Hazard and forwarding
    // ==============================
    assign rs1_hazard = is_pending && rs1_read && (rs1 == rpend);
    assign rs2_hazard = is_pending && rs2_read && (rs2 == rpend);

    // Pending result sits in our own output register once valid
    assign a_op = rs1_hazard ? ex_result : op1;
    assign b_op = rs2_hazard ? ex_result : op2;

    // Wait while the pending result is still being computed
    assign stall   = (rs1_hazard || rs2_hazard) && !ex_vld;
    assign dec_rdy = (state == EX1) && (!ex_vld || ex_rdy) && !stall;
    assign accept  = dec_vld && dec_rdy;

    // ==============================
    // Adder
    // ==============================
    // Carry-select, low half and both high halves in cycle 1
    assign adder_b = neg ? ~b_op : b_op;

    always_ff @(posedge clk) begin
        {cout_rl, adder_rl}   <= {1'b0, a_op[15:0]} + {1'b0, adder_b[15:0]} + {16'b0, cin};
        {cout_rh0, adder_rh0} <= {1'b0, a_op[31:16]} + {1'b0, adder_b[31:16]};
        {cout_rh1, adder_rh1} <= {1'b0, a_op[31:16]} + {1'b0, adder_b[31:16]} + 17'd1;
    end

    // Low carry picks the high half in cycle 2
    assign adder_rh = cout_rl ? adder_rh1 : adder_rh0;
    assign cout     = cout_rl ? cout_rh1 : cout_rh0;
    assign r_adder  = {adder_rh, adder_rl};

    // ==============================
    // Logic
    // ==============================
    // Stowed in cycle 1
    always_ff @(posedge clk) begin
        case (sel)
            SEL_AND: r_logic <= a_op & b_op;
            SEL_OR:  r_logic <= a_op | b_op;
            default: r_logic <= a_op ^ b_op;
        endcase
    end

    // ==============================
    // Comparator
    // ==============================
    always_ff @(posedge clk) begin
        a_sign    <= a_op[31];
        b_sign    <= b_op[31];
        check_uns <= uns;
        check_eq  <= eq;
        invert    <= inv;
        // Equality split in halves
        eq_lo     <= (a_op[15:0] == b_op[15:0]);
        eq_hi     <= (a_op[31:16] == b_op[31:16]);
    end

    always_comb begin
        // Same signs cannot overflow, so the difference sign decides
        if (a_sign != b_sign) begin
            lt = a_sign;
        end else begin
            lt = r_adder[31];
        end
        // No carry out of op1 - op2 means op1 < op2 unsigned
        ltu   = !cout;
        op_eq = eq_lo && eq_hi;
        if (check_eq) begin
            r_comp = op_eq ^ invert;
        end else if (check_uns) begin
            r_comp = ltu ^ invert;
        end else begin
            r_comp = lt ^ invert;
        end
    end

    // ==============================
    // Barrel shifter
    // ==============================
    // Right shifter only; left shifts reverse the data in and out
    assign data     = rev ? {<<{a_op}} : a_op;
    assign shift_in = (uns || rev) ? 1'b0 : a_op[31];

    // Levels 0 and 1 in cycle 1
    assign p0 = b_op[0] ? {shift_in, data[31:1]} : data;
    assign p1 = b_op[1] ? {{2{shift_in}}, p0[31:2]} : p0;

    always_ff @(posedge clk) begin
        tdata     <= p1;
        tshift_in <= shift_in;
        shift_rev <= rev;
        shamt_hi  <= b_op[`ALU_SHW-1:2];
    end

    // Levels 2 to 4 in cycle 2
    assign p2      = shamt_hi[2] ? {{4{tshift_in}}, tdata[31:4]} : tdata;
    assign p3      = shamt_hi[3] ? {{8{tshift_in}}, p2[31:8]} : p2;
    assign p4      = shamt_hi[4] ? {{16{tshift_in}}, p3[31:16]} : p3;
    assign r_shift = shift_rev ? {<<{p4}} : p4;

    // ==============================
    // Sequencer and output register
    // ==============================
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= EX1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            EX1: if (accept) next_state = EX2;
            default: next_state = EX1;
        endcase
    end

    always_ff @(posedge clk) begin
        result_sel <= sel;
    end

    always_comb begin
        case (result_sel)
            SEL_AND, SEL_OR, SEL_XOR: r_sel = r_logic;
            SEL_COMP:  r_sel = {{(`ALU_XLEN-1){1'b0}}, r_comp};
            SEL_SHIFT: r_sel = r_shift;
            default:   r_sel = r_adder;
        endcase
    end

    // Output valid and scoreboard
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ex_vld     <= 1'b0;
            is_pending <= 1'b0;
        end else if (accept) begin
            // Any older result leaves on this same edge
            ex_vld     <= 1'b0;
            is_pending <= rd_write && (rd != '0);
        end else if (state == EX2) begin
            ex_vld <= 1'b1;
        end else if (ex_vld && ex_rdy) begin
            ex_vld     <= 1'b0;
            is_pending <= 1'b0;
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (accept) begin
            rpend       <= rd;
            ex_rd       <= rd;
            ex_rd_write <= rd_write;
            ex_illegal  <= illegal;
        end
        if (state == EX2) begin
            // Illegal commands report a zero result
            ex_result <= ex_illegal ? '0 : r_sel;
        end
    end

endmodule

/* hw/alu_pkg.sv */
// Shared types and opcode encodings for the execute cluster
// Opcodes 14 and 15 are not defined and decode as illegal
`include "alu_defines.svh"

package alu_pkg;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [`ALU_XLEN-1:0] word_t;
    typedef logic [`ALU_REGW-1:0] regidx_t;
    typedef logic [3:0]           aluop_t;
    typedef logic [2:0]           alusel_t;

    // Command opcodes
    localparam aluop_t ADD  = 4'd0;
    localparam aluop_t SUB  = 4'd1;
    localparam aluop_t AND  = 4'd2;
    localparam aluop_t OR   = 4'd3;
    localparam aluop_t XOR  = 4'd4;
    localparam aluop_t SLT  = 4'd5;
    localparam aluop_t SLTU = 4'd6;
    localparam aluop_t SGE  = 4'd7;
    localparam aluop_t SGEU = 4'd8;
    localparam aluop_t SEQ  = 4'd9;
    localparam aluop_t SNE  = 4'd10;
    localparam aluop_t SLL  = 4'd11;
    localparam aluop_t SRL  = 4'd12;
    localparam aluop_t SRA  = 4'd13;

    // Result select of the execute stage
    localparam alusel_t SEL_ADDER = 3'd0;
    localparam alusel_t SEL_AND   = 3'd1;
    localparam alusel_t SEL_OR    = 3'd2;
    localparam alusel_t SEL_XOR   = 3'd3;
    localparam alusel_t SEL_COMP  = 3'd4;
    localparam alusel_t SEL_SHIFT = 3'd5;

    // Execute sequencer state
    typedef enum logic {
        EX1,
        EX2
    } ex_state_t;

endpackage

/* hw/alu_regfile.sv */
// Register file with x0 tied to zero; reads are combinational
// A write on the same edge is bypassed to both read ports
`include "alu_defines.svh"

module alu_regfile
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rstz,
    input  regidx_t raddr1,
    input  regidx_t raddr2,
    output word_t   rdata1,
    output word_t   rdata2,
    input  logic    we,
    input  regidx_t waddr,
    input  word_t   wdata
);

    // Only x1..x31 have storage
    word_t regs [1:`ALU_NREGS-1];

    // One read port, with x0 and write-through handling
    function automatic word_t read_port(regidx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 1; i < `ALU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

/* hw/alu_writeback.sv */
// One-entry result stage; the register write happens on the capture edge
// The result is presented until the outside accepts it
module alu_writeback
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rstz,
    // From execute
    input  logic    ex_vld,
    output logic    ex_rdy,
    input  regidx_t ex_rd,
    input  logic    ex_rd_write,
    input  logic    ex_illegal,
    input  word_t   ex_result,
    // Register file write port
    output logic    rf_we,
    output regidx_t rf_waddr,
    output word_t   rf_wdata,
    // Result port
    output logic    res_vld,
    input  logic    res_rdy,
    output regidx_t res_rd,
    output word_t   res_data,
    output logic    res_illegal
);

    logic capture;

    assign ex_rdy  = !res_vld || res_rdy;
    assign capture = ex_vld && ex_rdy;

    // Commit straight from the execute output, never to x0
    assign rf_we    = capture && ex_rd_write && !ex_illegal && (ex_rd != '0);
    assign rf_waddr = ex_rd;
    assign rf_wdata = ex_result;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            res_vld <= 1'b0;
        end else if (capture) begin
            res_vld <= 1'b1;
        end else if (res_rdy) begin
            res_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            res_rd      <= ex_rd;
            res_data    <= ex_result;
            res_illegal <= ex_illegal;
        end
    end

endmodule

/* list.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_regfile.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_writeback.sv
hw/alu_core_top.sv
sim/alu_clkgen.sv
sim/alu_sva.sv
sim/alu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/alu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

/* sim/alu_clkgen.sv */
// Free-running 4 ns clock; reset held low for the first 16 rising edges
module alu_clkgen (
    output logic clk,
    output logic rstz
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk  = 1'b0;
        rstz = 1'b0;
        // Release on a rising edge after 16 cycles
        repeat (16) @(posedge clk);
        rstz <= 1'b1;
    end

    always #2 clk = ~clk;

endmodule

/* sim/alu_sva.sv */
// Handshake and reset properties, bound into the cluster top
// Hold checks are disabled while reset is low
module alu_sva
    import alu_pkg::*;
(
    input logic    clk,
    input logic    rstz,
    input logic    dec_vld,
    input logic    ex_vld,
    input logic    ex_rdy,
    input regidx_t ex_rd,
    input word_t   ex_result,
    input logic    res_vld,
    input logic    res_rdy,
    input regidx_t res_rd,
    input word_t   res_data,
    input logic    res_illegal,
    input logic    rf_we,
    input regidx_t rf_waddr
);
    timeunit 1ns;
    timeprecision 100ps;

    // Result port holds until taken
    res_hold: assert property (@(posedge clk) disable iff (!rstz)
        res_vld && !res_rdy |=> res_vld && $stable(res_data) && $stable(res_rd)
            && $stable(res_illegal))
        else $error("res_vld dropped or payload changed before res_rdy");

    // Execute output holds until writeback takes it
    ex_hold: assert property (@(posedge clk) disable iff (!rstz)
        ex_vld && !ex_rdy |=> ex_vld && $stable(ex_result) && $stable(ex_rd))
        else $error("ex_vld dropped or payload changed before ex_rdy");

    // Nothing valid while in reset
    reset_quiet: assert property (@(posedge clk)
        !rstz |-> !dec_vld && !ex_vld && !res_vld && !rf_we)
        else $error("valid or write enable high during reset");

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clk) disable iff (!rstz)
        rf_we |-> rf_waddr != '0)
        else $error("register file write aimed at x0");

endmodule

bind alu_core_top alu_sva u_sva (
    .clk, .rstz, .dec_vld, .ex_vld, .ex_rdy, .ex_rd, .ex_result,
    .res_vld, .res_rdy, .res_rd, .res_data, .res_illegal, .rf_we, .rf_waddr
);

/* sim/alu_tb.sv */
// Directed tests against a register model; results must leave in command order
// Random operands and res_rdy stalls come from a 32 bit Galois LFSR
module alu_tb
    import alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;

    logic clk, rstz;
    logic cmd_vld, cmd_rdy, cmd_use_imm, cmd_rd_write;
    aluop_t cmd_op;
    regidx_t cmd_rd, cmd_rs1, cmd_rs2, res_rd;
    word_t cmd_imm, res_data;
    logic res_vld, res_rdy, res_illegal;

    logic [31:0] lfsr = 32'hbdd0;
    bit bp_on = 1'b0;
    int errors = 0;
    int checks = 0;
    word_t model_regs [32];
    regidx_t exp_rd [$];
    word_t exp_data [$];
    logic exp_ill [$];

    alu_clkgen u_clkgen (.clk, .rstz);

    alu_core_top u_dut (
        .clk, .rstz, .cmd_vld, .cmd_rdy, .cmd_op, .cmd_rd, .cmd_rs1, .cmd_rs2,
        .cmd_imm, .cmd_use_imm, .cmd_rd_write,
        .res_vld, .res_rdy, .res_rd, .res_data, .res_illegal
    );

    // ==============================
    // Random source and checks
    // ==============================
    // One LFSR step per bit taken
    function word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(string name, regidx_t got, regidx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(string why);
        errors++;
        $display("%s", why);
        $display("Errors found");
        $finish;
    endtask

    // Expected ALU result from the opcode rules
    function automatic word_t alu_ref(aluop_t op, word_t a, word_t b);
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLT:  return word_t'($signed(a) < $signed(b));
            SLTU: return word_t'(a < b);
            SGE:  return word_t'($signed(a) >= $signed(b));
            SGEU: return word_t'(a >= b);
            SEQ:  return word_t'(a == b);
            SNE:  return word_t'(a != b);
            SLL:  return a << b[4:0];
            SRL:  return a >> b[4:0];
            SRA:  return $signed(a) >>> b[4:0];
            default: return '0;
        endcase
    endfunction

    // ==============================
    // Command driver
    // ==============================
    // Called just after a rising edge; returns on the transfer edge
    task automatic send(aluop_t op, regidx_t rd, regidx_t rs1, regidx_t rs2,
                        word_t imm, logic use_imm, logic wr);
        word_t a, b, r;
        logic ill;
        int n;
        a = model_regs[rs1];
        b = use_imm ? imm : model_regs[rs2];
        ill = (op > SRA);
        r = ill ? '0 : alu_ref(op, a, b);
        if (wr && !ill && rd != '0) model_regs[rd] = r;
        exp_rd.push_back(rd);
        exp_data.push_back(r);
        exp_ill.push_back(ill);
        cmd_vld      <= 1'b1;
        cmd_op       <= op;
        cmd_rd       <= rd;
        cmd_rs1      <= rs1;
        cmd_rs2      <= rs2;
        cmd_imm      <= imm;
        cmd_use_imm  <= use_imm;
        cmd_rd_write <= wr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("Timeout: cmd_rdy never rose");
        end while (!cmd_rdy);
        @(posedge clk);
    endtask

    task automatic load(regidx_t rd, word_t val);
        send(ADD, rd, 5'd0, 5'd0, val, 1'b1, 1'b1);
    endtask

    // Stop issuing and wait for every result to come back
    task automatic drain();
        int n;
        cmd_vld <= 1'b0;
        n = 0;
        while (exp_rd.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("Timeout: results still outstanding");
        end
        @(posedge clk);
    endtask

    // Results are compared at the falling edge before the transfer
    initial begin
        forever begin
            @(negedge clk);
            if (rstz && res_vld && res_rdy) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("Result arrived with no command outstanding");
                end else begin
                    check_idx("res_rd", res_rd, exp_rd.pop_front());
                    check_word("res_data", res_data, exp_data.pop_front());
                    check_bit("res_illegal", res_illegal, exp_ill.pop_front());
                end
            end
        end
    end

    initial begin
        res_rdy = 1'b1;
        forever begin
            @(posedge clk);
            res_rdy <= bp_on ? 1'(rand_bits(1)) : 1'b1;
        end
    end

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_arith();
        load(5'd1, 32'h0000ffff);
        load(5'd2, 32'h00000001);
        load(5'd3, 32'hffffffff);
        load(5'd4, 32'h7fffffff);
        load(5'd5, 32'h80000000);
        // Carry across bit 16, then wraparound both ways
        send(ADD, 5'd6, 5'd1, 5'd2, '0, 1'b0, 1'b1);
        send(ADD, 5'd7, 5'd3, 5'd2, '0, 1'b0, 1'b1);
        send(ADD, 5'd8, 5'd4, 5'd2, '0, 1'b0, 1'b1);
        send(SUB, 5'd9, 5'd5, 5'd2, '0, 1'b0, 1'b1);
        send(SUB, 5'd10, 5'd0, 5'd2, '0, 1'b0, 1'b1);
        drain();
    endtask

    task automatic test_logic();
        for (int i = 0; i < 6; i++) begin
            load(5'd10, rand_bits(32));
            load(5'd11, rand_bits(32));
            send(AND, 5'd12, 5'd10, 5'd11, '0, 1'b0, 1'b1);
            send(OR, 5'd12, 5'd10, 5'd11, '0, 1'b0, 1'b1);
            send(XOR, 5'd12, 5'd10, 5'd11, '0, 1'b0, 1'b1);
            send(aluop_t'(AND + i % 3), 5'd13, 5'd10, 5'd0, rand_bits(32), 1'b1, 1'b1);
        end
        drain();
    endtask

    task automatic test_compare();
        word_t pa [6] = '{32'd5, 32'hffffffff, 32'h80000000, 32'h0, 32'h7fffffff, 32'h1234};
        word_t pb [6] = '{32'd5, 32'h1, 32'h7fffffff, 32'hffffffff, 32'h80000000, 32'h1234};
        for (int i = 0; i < 7; i++) begin
            load(5'd12, i < 6 ? pa[i] : rand_bits(32));
            load(5'd13, i < 6 ? pb[i] : rand_bits(32));
            for (int k = 0; k < 6; k++) begin
                send(aluop_t'(SLT + k), 5'd14, 5'd12, 5'd13, '0, 1'b0, 1'b1);
            end
        end
        drain();
    endtask

    task automatic test_shift();
        load(5'd15, 32'h8421f0f1);
        for (int sh = 0; sh < 32; sh++) begin
            // Upper op2 bits are junk the shifter must ignore
            send(SLL, 5'd16, 5'd15, 5'd0, {27'(rand_bits(27)), 5'(sh)}, 1'b1, 1'b1);
            send(SRL, 5'd16, 5'd15, 5'd0, {27'(rand_bits(27)), 5'(sh)}, 1'b1, 1'b1);
            send(SRA, 5'd16, 5'd15, 5'd0, {27'(rand_bits(27)), 5'(sh)}, 1'b1, 1'b1);
        end
        load(5'd17, 32'hffffffe3);
        send(SRA, 5'd18, 5'd15, 5'd17, '0, 1'b0, 1'b1);
        drain();
    endtask

    // Each command reads the destination of the one before it
    task automatic test_chain(bit bp);
        aluop_t ops [6] = '{ADD, SUB, XOR, SLL, SLT, OR};
        bp_on = bp;
        load(5'd16, rand_bits(32));
        load(5'd17, rand_bits(32));
        load(5'd18, rand_bits(32));
        for (int i = 0; i < 18; i++) begin
            send(ops[i % 6], regidx_t'(16 + (i + 1) % 3), regidx_t'(16 + i % 3),
                 regidx_t'(16 + (i + 2) % 3), rand_bits(32), 1'(rand_bits(1)), 1'b1);
        end
        drain();
        bp_on = 1'b0;
    endtask

    task automatic test_illegal();
        // Nonzero contents so a stray write shows up on the later reads
        load(5'd20, 32'h13579bdf);
        load(5'd21, 32'h2468ace0);
        send(aluop_t'(14), 5'd20, 5'd1, 5'd2, '0, 1'b0, 1'b1);
        send(aluop_t'(15), 5'd21, 5'd0, 5'd0, 32'd5, 1'b1, 1'b1);
        send(ADD, 5'd22, 5'd20, 5'd0, '0, 1'b1, 1'b1);
        send(ADD, 5'd0, 5'd1, 5'd0, 32'h55, 1'b1, 1'b1);
        send(ADD, 5'd23, 5'd0, 5'd0, '0, 1'b1, 1'b1);
        // Write flag low leaves x24 alone
        send(ADD, 5'd24, 5'd1, 5'd0, 32'd7, 1'b1, 1'b0);
        send(OR, 5'd25, 5'd24, 5'd21, '0, 1'b0, 1'b1);
        drain();
    endtask

    initial begin
        int n;
        cmd_vld      = 1'b0;
        cmd_op       = ADD;
        cmd_rd       = '0;
        cmd_rs1      = '0;
        cmd_rs2      = '0;
        cmd_imm      = '0;
        cmd_use_imm  = 1'b0;
        cmd_rd_write = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;
        // Start on the first rising edge after reset release
        n = 0;
        while (!rstz) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("Timeout: reset was never released");
        end
        test_arith();
        test_logic();
        test_compare();
        test_shift();
        test_chain(1'b0);
        test_chain(1'b1);
        test_illegal();
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
